// File: neo_sample_top.f
rtl/neo_sample_pkg.sv
rtl/cart_loader.sv
rtl/adpcm_fetch.sv
rtl/sample_arbiter.sv
rtl/sample_ram.sv
rtl/neo_sample_top.sv
testbench/neo_sample_asserts.sv
testbench/tb_neo_sample_top.sv

// File: rtl/adpcm_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module adpcm_fetch #(
	parameter neo_sample_pkg::chan_t CHAN = neo_sample_pkg::CHAN_A
) (
	input wire CLK_48M,
	input wire reset,
	input wire rd,
	input wire [neo_sample_pkg::SAMPLE_AW-1:0] addr,
	input wire neo_sample_pkg::cart_layout_t layout,
	input wire mem_ack,
	input wire [31:0] mem_word,
	output logic mem_req,
	output logic [neo_sample_pkg::ROM_AW-1:0] mem_addr,
	output logic [7:0] data,
	output logic ready
);
	import neo_sample_pkg::*;

	logic rd_d;
	logic rd_rise;
	logic word_valid;
	logic use_v2;
	logic [SAMPLE_AW-1:0] mask;
	logic [SAMPLE_AW-1:0] masked;
	logic [SAMPLE_AW-1:0] latch;

	// Merged carts keep B samples inside V1
	assign use_v2 = (CHAN == CHAN_B) && !layout.pcm_merged;
	assign mask = use_v2 ? layout.v2_mask : layout.v1_mask;
	assign masked = addr & mask;
	assign rd_rise = rd && !rd_d;

	always_ff @(posedge CLK_48M) begin
		if (reset) begin
			rd_d <= 1'b0;
			mem_req <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			rd_d <= rd;
			if (!layout.adpcm_en) begin
				word_valid <= 1'b0;
			end else if (rd_rise) begin
				// Same word already held, no memory access
				if (!word_valid || masked[SAMPLE_AW-1:2] != latch[SAMPLE_AW-1:2])
					mem_req <= ~mem_req;
				word_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (rd_rise && layout.adpcm_en)
			latch <= masked;
	end

	assign mem_addr = layout.c_size + ROM_AW'(latch) + (use_v2 ? layout.v1_size : '0);
	assign ready = mem_req == mem_ack;

	always_comb begin
		if (!layout.adpcm_en)
			data = SILENT_SAMPLE;
		else
			data = mem_word[{latch[1:0], 3'b000} +: 8];
	end

endmodule

`default_nettype wire

// File: rtl/cart_loader.sv
`timescale 1ns/1ps
`default_nettype none

module cart_loader (
	input wire CLK_48M,
	input wire reset,
	input wire ioctl_download,
	input wire [7:0] ioctl_index,
	input wire ioctl_wr,
	input wire [neo_sample_pkg::IOCTL_AW-1:0] ioctl_addr,
	input wire [7:0] ioctl_dout,
	input wire wr_ack,
	output logic wr_req,
	output logic [neo_sample_pkg::ROM_AW-1:0] wr_addr,
	output logic [7:0] wr_data,
	output neo_sample_pkg::cart_layout_t layout
);
	import neo_sample_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_COUNT,
		ST_CHECK
	} step_t;

	// Sizes P..C, element index is the region code
	logic [5:0][31:0] size_sr;
	logic [ROM_AW-1:0] offset;
	logic [ROM_AW-1:0] region_size;
	logic [SAMPLE_AW-1:0] mask_v1;
	logic [SAMPLE_AW-1:0] mask_v2;
	logic merged;
	logic adpcm_on;
	logic cart_write;
	logic no_adpcm;
	logic in_header;
	logic sample_region;
	region_t region;
	step_t step;

	function automatic logic [SAMPLE_AW-1:0] pow2_mask(input logic [ROM_AW-1:0] size);
		logic [4:0] top;
		int ones;
		top = '0;
		ones = 0;
		for (int i = 0; i < ROM_AW; i++) begin
			if (size[i]) begin
				top = 5'(i);
				ones++;
			end
		end
		// Round up when not already a power of two
		if (ones > 1)
			top = top + 5'd1;
		return SAMPLE_AW'((32'd1 << top) - 32'd1);
	endfunction

	assign cart_write = ioctl_download && (ioctl_index == 8'd1 || ioctl_index == 8'd2);
	assign no_adpcm = ioctl_index == 8'd2;
	assign in_header = ioctl_addr < IOCTL_AW'(HEADER_BYTES);
	assign region_size = size_sr[region][ROM_AW-1:0];
	assign sample_region = (region == REG_V1 || region == REG_V2) && !no_adpcm;

	// C sits first in sample memory, then V1, then V2
	assign wr_addr = size_sr[REG_C][ROM_AW-1:0] + offset +
		((region == REG_V2) ? size_sr[REG_V1][ROM_AW-1:0] : '0);

	always_ff @(posedge CLK_48M) begin
		if (reset) begin
			step <= ST_IDLE;
			region <= REG_P;
			offset <= '0;
			wr_req <= 1'b0;
			merged <= 1'b0;
			adpcm_on <= 1'b0;
		end else begin
			if (ioctl_wr && cart_write) begin
				if (in_header) begin
					region <= REG_P;
					offset <= '0;
					// Channels stay silent while the layout changes
					adpcm_on <= 1'b0;
					if (ioctl_addr == IOCTL_AW'(HEADER_BYTES - 1)) begin
						step <= ST_CHECK;
						merged <= size_sr[REG_V2] == '0;
						adpcm_on <= !no_adpcm;
					end
				end else begin
					if (sample_region)
						wr_req <= ~wr_req;
					step <= ST_COUNT;
				end
			end

			case (step)
				ST_COUNT: begin
					if (wr_req == wr_ack) begin
						offset <= offset + 1'b1;
						step <= ST_CHECK;
					end
				end
				ST_CHECK: begin
					// Keep walking while regions are empty
					if (offset == region_size) begin
						offset <= '0;
						if (region == REG_C)
							step <= ST_IDLE;
						else
							region <= region_t'(region + 3'd1);
					end else begin
						step <= ST_IDLE;
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (ioctl_wr && cart_write && ioctl_addr >= IOCTL_AW'(4) && ioctl_addr < IOCTL_AW'(28))
			size_sr <= {ioctl_dout, size_sr[5:1], size_sr[0][31:8]};
		if (ioctl_wr && cart_write && !in_header)
			wr_data <= ioctl_dout;
		if (cart_write) begin
			mask_v1 <= pow2_mask(size_sr[REG_V1][ROM_AW-1:0]);
			mask_v2 <= pow2_mask(size_sr[REG_V2][ROM_AW-1:0]);
		end
	end

	assign layout = '{
		c_size: size_sr[REG_C][ROM_AW-1:0],
		v1_size: size_sr[REG_V1][ROM_AW-1:0],
		v2_size: size_sr[REG_V2][ROM_AW-1:0],
		v1_mask: mask_v1,
		v2_mask: mask_v2,
		pcm_merged: merged,
		adpcm_en: adpcm_on
	};

endmodule

`default_nettype wire

// File: rtl/neo_sample_pkg.sv
`default_nettype none

package neo_sample_pkg;

	// Host download side
	localparam int IOCTL_AW = 27;
	localparam int HEADER_BYTES = 4096;

	// Sample fetch side
	localparam int SAMPLE_AW = 24;
	localparam logic [7:0] SILENT_SAMPLE = 8'h80;

	// Byte address into the shared sample memory and its word part
	localparam int ROM_AW = 26;
	localparam int MEM_WORD_AW = ROM_AW - 2;

	// Region order as it appears in a .NEO file
	typedef enum logic [2:0] {
		REG_P,
		REG_S,
		REG_M,
		REG_V1,
		REG_V2,
		REG_C
	} region_t;

	typedef enum logic {
		CHAN_A,
		CHAN_B
	} chan_t;

	typedef struct packed {
		logic [ROM_AW-1:0] c_size;
		logic [ROM_AW-1:0] v1_size;
		logic [ROM_AW-1:0] v2_size;
		logic [SAMPLE_AW-1:0] v1_mask;
		logic [SAMPLE_AW-1:0] v2_mask;
		logic pcm_merged;
		logic adpcm_en;
	} cart_layout_t;

	// Upper word address bits wrap inside the RAM
	typedef struct packed {
		logic [MEM_WORD_AW-1:0] addr;
		logic we;
		logic [3:0] be;
		logic [31:0] wdata;
	} mem_req_t;

endpackage

`default_nettype wire

// File: rtl/neo_sample_top.sv
`timescale 1ns/1ps
`default_nettype none

module neo_sample_top #(
	parameter int MEM_AW = 14
) (
	input wire CLK_48M,
	input wire reset,
	input wire ioctl_download,
	input wire [7:0] ioctl_index,
	input wire ioctl_wr,
	input wire [neo_sample_pkg::IOCTL_AW-1:0] ioctl_addr,
	input wire [7:0] ioctl_dout,
	input wire adpcma_rd,
	input wire [19:0] adpcma_addr,
	input wire [3:0] adpcma_bank,
	input wire adpcmb_rd,
	input wire [23:0] adpcmb_addr,
	output logic [7:0] adpcma_data,
	output logic adpcma_ready,
	output logic [7:0] adpcmb_data,
	output logic adpcmb_ready
);
	import neo_sample_pkg::*;

	cart_layout_t layout;
	mem_req_t mem;
	logic [31:0] mem_q;
	logic wr_req;
	logic wr_ack;
	logic [ROM_AW-1:0] wr_addr;
	logic [7:0] wr_data;
	logic a_req;
	logic a_ack;
	logic [ROM_AW-1:0] a_addr;
	logic [31:0] a_word;
	logic b_req;
	logic b_ack;
	logic [ROM_AW-1:0] b_addr;
	logic [31:0] b_word;

	cart_loader u_cart_loader (
		.CLK_48M(CLK_48M),
		.reset(reset),
		.ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.wr_ack(wr_ack),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.layout(layout)
	);

	// Channel A sees its bank above the 20-bit address
	adpcm_fetch #(.CHAN(CHAN_A)) u_fetch_a (
		.CLK_48M(CLK_48M),
		.reset(reset),
		.rd(adpcma_rd),
		.addr({adpcma_bank, adpcma_addr}),
		.layout(layout),
		.mem_ack(a_ack),
		.mem_word(a_word),
		.mem_req(a_req),
		.mem_addr(a_addr),
		.data(adpcma_data),
		.ready(adpcma_ready)
	);

	adpcm_fetch #(.CHAN(CHAN_B)) u_fetch_b (
		.CLK_48M(CLK_48M),
		.reset(reset),
		.rd(adpcmb_rd),
		.addr(adpcmb_addr),
		.layout(layout),
		.mem_ack(b_ack),
		.mem_word(b_word),
		.mem_req(b_req),
		.mem_addr(b_addr),
		.data(adpcmb_data),
		.ready(adpcmb_ready)
	);

	sample_arbiter #(.MEM_AW(MEM_AW)) u_sample_arbiter (
		.CLK_48M(CLK_48M),
		.reset(reset),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.a_req(a_req),
		.a_addr(a_addr),
		.b_req(b_req),
		.b_addr(b_addr),
		.wr_ack(wr_ack),
		.a_ack(a_ack),
		.a_word(a_word),
		.b_ack(b_ack),
		.b_word(b_word),
		.mem(mem),
		.mem_q(mem_q)
	);

	sample_ram #(.MEM_AW(MEM_AW)) u_sample_ram (
		.CLK_48M(CLK_48M),
		.mem(mem),
		.mem_q(mem_q)
	);

endmodule

`default_nettype wire

// File: rtl/sample_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sample_arbiter #(
	parameter int MEM_AW = 14
) (
	input wire CLK_48M,
	input wire reset,
	input wire wr_req,
	input wire [neo_sample_pkg::ROM_AW-1:0] wr_addr,
	input wire [7:0] wr_data,
	input wire a_req,
	input wire [neo_sample_pkg::ROM_AW-1:0] a_addr,
	input wire b_req,
	input wire [neo_sample_pkg::ROM_AW-1:0] b_addr,
	output logic wr_ack,
	output logic a_ack,
	output logic [31:0] a_word,
	output logic b_ack,
	output logic [31:0] b_word,
	output neo_sample_pkg::mem_req_t mem,
	input wire [31:0] mem_q
);
	import neo_sample_pkg::*;

	typedef enum logic [1:0] {
		OWN_LOADER,
		OWN_A,
		OWN_B
	} owner_t;

	logic wr_pend;
	logic a_pend;
	logic b_pend;
	logic any_pend;
	logic busy;
	logic phase;
	owner_t owner;
	owner_t sel;
	logic [ROM_AW-1:0] sel_addr;
	mem_req_t mem_next;

	assign wr_pend = wr_req != wr_ack;
	assign a_pend = a_req != a_ack;
	assign b_pend = b_req != b_ack;
	assign any_pend = wr_pend | a_pend | b_pend;

	// Fixed priority: loader, then A, then B
	always_comb begin
		sel = OWN_B;
		sel_addr = b_addr;
		if (wr_pend) begin
			sel = OWN_LOADER;
			sel_addr = wr_addr;
		end else if (a_pend) begin
			sel = OWN_A;
			sel_addr = a_addr;
		end
		mem_next.addr = MEM_WORD_AW'(sel_addr[MEM_AW-1:2]);
		mem_next.we = sel == OWN_LOADER;
		mem_next.be = (sel == OWN_LOADER) ? 4'b0001 << sel_addr[1:0] : 4'b1111;
		mem_next.wdata = {4{wr_data}};
	end

	always_ff @(posedge CLK_48M) begin
		if (reset) begin
			busy <= 1'b0;
			phase <= 1'b0;
			owner <= OWN_LOADER;
			wr_ack <= 1'b0;
			a_ack <= 1'b0;
			b_ack <= 1'b0;
			mem.we <= 1'b0;
		end else if (!busy) begin
			if (any_pend) begin
				busy <= 1'b1;
				phase <= 1'b0;
				owner <= sel;
				mem <= mem_next;
			end
		end else if (!phase) begin
			// RAM takes the access on this edge
			phase <= 1'b1;
			mem.we <= 1'b0;
		end else begin
			busy <= 1'b0;
			case (owner)
				OWN_LOADER: wr_ack <= ~wr_ack;
				OWN_A: a_ack <= ~a_ack;
				default: b_ack <= ~b_ack;
			endcase
		end
	end

	// Read data stays put until the channel's next access completes
	always_ff @(posedge CLK_48M) begin
		if (busy && phase) begin
			if (owner == OWN_A)
				a_word <= mem_q;
			if (owner == OWN_B)
				b_word <= mem_q;
		end
	end

endmodule

`default_nettype wire

// File: rtl/sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ram #(
	parameter int MEM_AW = 14
) (
	input wire CLK_48M,
	input wire neo_sample_pkg::mem_req_t mem,
	output logic [31:0] mem_q
);

	localparam int WORDS = 2 ** (MEM_AW - 2);

	logic [31:0] ram [0:WORDS-1];
	logic [MEM_AW-3:0] waddr;

	// Only the low word address bits are decoded
	assign waddr = mem.addr[MEM_AW-3:0];

	always_ff @(posedge CLK_48M) begin
		if (mem.we) begin
			for (int i = 0; i < 4; i++) begin
				if (mem.be[i])
					ram[waddr][i*8 +: 8] <= mem.wdata[i*8 +: 8];
			end
		end
		mem_q <= ram[waddr];
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sample path regression with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_neo_sample_top -f neo_sample_top.f -o sim_neo_sample; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_neo_sample +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1

// File: testbench/neo_sample_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module neo_sample_asserts (
	input wire CLK_48M,
	input wire reset,
	input wire wr_req,
	input wire wr_ack,
	input wire a_req,
	input wire a_ack,
	input wire b_req,
	input wire b_ack,
	input wire busy,
	input wire [1:0] owner,
	input wire mem_we
);

	int fail_count = 0;

	// An ack may only answer a pending request
	wr_ack_pending: assert property (@(posedge CLK_48M) disable iff (reset)
		(wr_ack != $past(wr_ack)) |-> $past(wr_req != wr_ack))
		else begin
			fail_count++;
			$error("wr_ack toggled with no loader request pending");
		end

	a_ack_pending: assert property (@(posedge CLK_48M) disable iff (reset)
		(a_ack != $past(a_ack)) |-> $past(a_req != a_ack))
		else begin
			fail_count++;
			$error("a_ack toggled with no channel A request pending");
		end

	b_ack_pending: assert property (@(posedge CLK_48M) disable iff (reset)
		(b_ack != $past(b_ack)) |-> $past(b_req != b_ack))
		else begin
			fail_count++;
			$error("b_ack toggled with no channel B request pending");
		end

	one_ack: assert property (@(posedge CLK_48M) disable iff (reset)
		$onehot0({wr_ack ^ $past(wr_ack), a_ack ^ $past(a_ack), b_ack ^ $past(b_ack)}))
		else begin
			fail_count++;
			$error("more than one ack toggled in one cycle");
		end

	// Owner code 0 is the loader
	we_loader_only: assert property (@(posedge CLK_48M) disable iff (reset)
		mem_we |-> (busy && owner == 2'd0))
		else begin
			fail_count++;
			$error("RAM write enable high without a loader grant");
		end

endmodule

`default_nettype wire

// File: testbench/tb_neo_sample_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_neo_sample_top;
	import neo_sample_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int MEM_AW = 14;
	localparam int WR_GAP = 10;
	localparam int READ_WAIT = 20;
	localparam int N_RANDOM = 40;
	localparam int N_PAIRS = 8;
	localparam int N_BANK = 12;
	localparam int N_MERGED = 24;
	localparam int N_SILENT = 6;
	// Data bytes of the full cart (loaded twice) and of the merged cart
	localparam int FULL_DATA = 5 + 3 + 300 + 148 + 36;
	localparam int MERGED_DATA = 2 + 92 + 20;
	localparam int LOAD_BYTES = 3 * HEADER_BYTES + 2 * FULL_DATA + MERGED_DATA;
	localparam int READ_COUNT = 2 * N_RANDOM + 2 * N_PAIRS + N_BANK + N_MERGED + 2 * N_SILENT;
	localparam int WATCHDOG_CYCLES = LOAD_BYTES * 12 + READ_COUNT * 20;

	logic CLK_48M;
	logic reset;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic ioctl_wr;
	logic [IOCTL_AW-1:0] ioctl_addr;
	logic [7:0] ioctl_dout;
	logic adpcma_rd;
	logic [19:0] adpcma_addr;
	logic [3:0] adpcma_bank;
	logic adpcmb_rd;
	logic [23:0] adpcmb_addr;
	logic [7:0] adpcma_data;
	logic adpcma_ready;
	logic [7:0] adpcmb_data;
	logic adpcmb_ready;

	integer seed;
	int errors;
	logic [7:0] cart [0:8191];
	logic [7:0] exp_mem [0:2**MEM_AW-1];
	int cart_len;
	int v1_start;
	int c_size;
	int v1_size;
	int v2_size;
	int v1_mask;

	neo_sample_top #(.MEM_AW(MEM_AW)) u_neo_sample_top (
		.CLK_48M(CLK_48M),
		.reset(reset),
		.ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.adpcma_rd(adpcma_rd),
		.adpcma_addr(adpcma_addr),
		.adpcma_bank(adpcma_bank),
		.adpcmb_rd(adpcmb_rd),
		.adpcmb_addr(adpcmb_addr),
		.adpcma_data(adpcma_data),
		.adpcma_ready(adpcma_ready),
		.adpcmb_data(adpcmb_data),
		.adpcmb_ready(adpcmb_ready)
	);

	bind sample_arbiter neo_sample_asserts u_asserts (
		.CLK_48M(CLK_48M),
		.reset(reset),
		.wr_req(wr_req),
		.wr_ack(wr_ack),
		.a_req(a_req),
		.a_ack(a_ack),
		.b_req(b_req),
		.b_ack(b_ack),
		.busy(busy),
		.owner(owner),
		.mem_we(mem.we)
	);

	initial begin
		CLK_48M = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_48M = ~CLK_48M;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK_48M);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

	task automatic step();
		@(posedge CLK_48M);
		#1;
	endtask

	task automatic value_error(input string name, input logic [7:0] exp, input logic [7:0] got);
		errors++;
		$display("Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Smallest power of two not below the size, minus one
	function automatic int size_mask(input int size);
		int m;
		m = 0;
		while (m + 1 < size)
			m = (m << 1) | 1;
		return m;
	endfunction

	// Channel B reads V1 when the cart has no V2
	function automatic logic [7:0] exp_byte(input bit chan_b, input int off);
		int base;
		base = c_size + ((chan_b && v2_size != 0) ? v1_size : 0);
		return exp_mem[base + off];
	endfunction

	function automatic logic chan_ready(input bit chan_b);
		return chan_b ? adpcmb_ready : adpcma_ready;
	endfunction

	function automatic logic [7:0] chan_data(input bit chan_b);
		return chan_b ? adpcmb_data : adpcma_data;
	endfunction

	task automatic build_cart(input int p, input int s, input int m, input int v1,
		input int v2, input int c);
		int sizes [6];
		int data_len;
		sizes = '{p, s, m, v1, v2, c};
		data_len = p + s + m + v1 + v2 + c;
		for (int i = 0; i < HEADER_BYTES; i++)
			cart[i] = 8'h00;
		// Little-endian sizes from byte 4
		for (int r = 0; r < 6; r++) begin
			for (int b = 0; b < 4; b++)
				cart[4 + r * 4 + b] = 8'(sizes[r] >> (8 * b));
		end
		for (int i = 0; i < data_len; i++)
			cart[HEADER_BYTES + i] = 8'($random(seed));
		cart_len = HEADER_BYTES + data_len;
		v1_start = HEADER_BYTES + p + s + m;
		c_size = c;
		v1_size = v1;
		v2_size = v2;
		v1_mask = size_mask(v1);
	endtask

	task automatic download_cart(input logic [7:0] index);
		ioctl_index = index;
		ioctl_download = 1'b1;
		for (int i = 0; i < cart_len; i++) begin
			ioctl_addr = IOCTL_AW'(i);
			ioctl_dout = cart[i];
			ioctl_wr = 1'b1;
			step();
			ioctl_wr = 1'b0;
			repeat (WR_GAP - 1) step();
		end
		ioctl_download = 1'b0;
		step();
		// Index 2 stores no samples
		if (index == 8'd1) begin
			for (int i = 0; i < v1_size; i++)
				exp_mem[c_size + i] = cart[v1_start + i];
			for (int i = 0; i < v2_size; i++)
				exp_mem[c_size + v1_size + i] = cart[v1_start + v1_size + i];
		end
	endtask

	task automatic read_byte(input bit chan_b, input logic [23:0] a, input logic [7:0] exp,
		input bit hold_ready);
		int waited;
		string name;
		string rdy_name;
		name = chan_b ? "adpcmb_data" : "adpcma_data";
		rdy_name = chan_b ? "adpcmb_ready" : "adpcma_ready";
		waited = 0;
		if (chan_b) begin
			adpcmb_addr = a;
			adpcmb_rd = 1'b1;
		end else begin
			adpcma_bank = a[23:20];
			adpcma_addr = a[19:0];
			adpcma_rd = 1'b1;
		end
		step();
		if (hold_ready) begin
			repeat (3) begin
				assert (chan_ready(chan_b))
					else value_error(rdy_name, 8'd1, 8'(chan_ready(chan_b)));
				step();
			end
		end
		while (!chan_ready(chan_b) && waited < READ_WAIT) begin
			step();
			waited++;
		end
		if (!chan_ready(chan_b)) begin
			errors++;
			$display("At %0t ns %s did not return high after a read", $time, rdy_name);
		end
		assert (chan_data(chan_b) == exp)
			else value_error(name, exp, chan_data(chan_b));
		adpcma_rd = 1'b0;
		adpcmb_rd = 1'b0;
		step();
	endtask

	initial begin
		int off;
		bit chan_b;
		logic [31:0] hi;
		int bound_errors;
		seed = 32'h3ce2_0d53;
		errors = 0;
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = 8'd0;
		adpcma_rd = 1'b0;
		adpcma_addr = 20'd0;
		adpcma_bank = 4'd0;
		adpcmb_rd = 1'b0;
		adpcmb_addr = 24'd0;
		repeat (4) @(posedge CLK_48M);
		#1;
		reset = 1'b0;
		step();

		assert (adpcma_ready) else value_error("adpcma_ready", 8'd1, 8'(adpcma_ready));
		assert (adpcmb_ready) else value_error("adpcmb_ready", 8'd1, 8'(adpcmb_ready));
		assert (adpcma_data == SILENT_SAMPLE) else value_error("adpcma_data", 8'h80, adpcma_data);
		assert (adpcmb_data == SILENT_SAMPLE) else value_error("adpcmb_data", 8'h80, adpcmb_data);

		// Sizes keep C and V1 word aligned
		build_cart(5, 0, 3, 300, 148, 36);
		download_cart(8'd1);
		for (int i = 0; i < N_RANDOM; i++) begin
			off = rand_below(v1_size);
			read_byte(1'b0, 24'(off), exp_byte(1'b0, off), 1'b0);
			off = rand_below(v2_size);
			read_byte(1'b1, 24'(off), exp_byte(1'b1, off), 1'b0);
		end
		for (int i = 0; i < N_PAIRS; i++) begin
			chan_b = i[0];
			off = rand_below((chan_b ? v2_size : v1_size) / 4) * 4;
			read_byte(chan_b, 24'(off), exp_byte(chan_b, off), 1'b0);
			off = off + 1 + rand_below(3);
			read_byte(chan_b, 24'(off), exp_byte(chan_b, off), 1'b1);
		end
		// Bank and high address bits fall outside the V1 mask
		for (int i = 0; i < N_BANK; i++) begin
			off = rand_below(v1_size);
			hi = $random(seed);
			read_byte(1'b0, (hi[23:0] & ~24'(v1_mask)) | 24'h10_0000 | 24'(off),
				exp_byte(1'b0, off), 1'b0);
		end

		build_cart(0, 2, 0, 92, 0, 20);
		download_cart(8'd1);
		for (int i = 0; i < N_MERGED; i++) begin
			off = rand_below(v1_size);
			hi = $random(seed);
			read_byte(1'b1, (hi[23:0] & ~24'(v1_mask)) | 24'(off), exp_byte(1'b1, off), 1'b0);
		end

		build_cart(5, 0, 3, 300, 148, 36);
		download_cart(8'd2);
		for (int i = 0; i < N_SILENT; i++) begin
			hi = $random(seed);
			read_byte(1'b0, hi[23:0], SILENT_SAMPLE, 1'b1);
			read_byte(1'b1, hi[31:8], SILENT_SAMPLE, 1'b1);
		end

		bound_errors = u_neo_sample_top.u_sample_arbiter.u_asserts.fail_count;
		$display("Errors: %0d testbench, %0d bound assertions", errors, bound_errors);
		if (errors == 0 && bound_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
